// ==== source/core_pkg.sv ====
package core_pkg;

    localparam int XLEN = 32;  // Integer register width.
    localparam int ILEN = 32;
    localparam int ALEN = 32;

    // Base opcodes of the supported RV32I groups.
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    localparam logic [ALEN-1:0] RESET_PC = '0;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_view_t;

    // Upper twelve bits hold the I-type immediate.
    typedef struct packed {
        logic [11:0] imm_hi;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } imm_view_t;

    typedef union packed {
        r_view_t   r;
        imm_view_t i;
    } instr_t;

endpackage

// ==== source/pipe_pkg.sv ====
package pipe_pkg;

    // ALU operations.
    localparam logic [3:0] ALU_ADD  = 4'd0;
    localparam logic [3:0] ALU_SUB  = 4'd1;
    localparam logic [3:0] ALU_SLL  = 4'd2;
    localparam logic [3:0] ALU_SLT  = 4'd3;
    localparam logic [3:0] ALU_SLTU = 4'd4;
    localparam logic [3:0] ALU_XOR  = 4'd5;
    localparam logic [3:0] ALU_SRL  = 4'd6;
    localparam logic [3:0] ALU_SRA  = 4'd7;
    localparam logic [3:0] ALU_OR   = 4'd8;
    localparam logic [3:0] ALU_AND  = 4'd9;

    // Source of ALU operand A.
    localparam logic [1:0] OPA_REG  = 2'd0;
    localparam logic [1:0] OPA_PC   = 2'd1;  // AUIPC and JAL.
    localparam logic [1:0] OPA_ZERO = 2'd2;  // LUI.

endpackage

// ==== source/pc_control.sv ====
`timescale 1ns/1ps

module pc_control (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      instr_retired,
    input  logic [core_pkg::ALEN-1:0] next_pc,
    output logic [core_pkg::ALEN-1:0] pc
);
    import core_pkg::*;

    // Architectural PC, moves only when an instruction retires.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= RESET_PC;
        end else if (instr_retired) begin
            pc <= next_pc;
        end
    end

endmodule

// ==== source/int_regfile.sv ====
`timescale 1ns/1ps

module int_regfile (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      write1_enable,
    input  logic [4:0]                write1_sel,
    input  logic [core_pkg::XLEN-1:0] write1_data,
    input  logic [4:0]                read1_sel,
    input  logic [4:0]                read2_sel,
    input  logic [4:0]                read3_sel,
    output logic [core_pkg::XLEN-1:0] read1_data,
    output logic [core_pkg::XLEN-1:0] read2_data,
    output logic [core_pkg::XLEN-1:0] read3_data
);
    import core_pkg::*;

    logic [XLEN-1:0] regs [32];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write1_enable && write1_sel != 5'd0) begin  // x0 stays zero.
            regs[write1_sel] <= write1_data;
        end
    end

    assign read1_data = regs[read1_sel];
    assign read2_data = regs[read2_sel];
    assign read3_data = regs[read3_sel];  // Debug port.

endmodule

// ==== source/ifetch.sv ====
`timescale 1ns/1ps

module ifetch (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      flush,
    input  logic [core_pkg::ALEN-1:0] flush_target,
    input  logic                      next_stalled,
    input  logic                      imem_valid,
    input  logic [core_pkg::ILEN-1:0] imem_rdata,
    output logic                      imem_req,
    output logic [core_pkg::ALEN-1:0] imem_addr,
    output core_pkg::instr_t          instruction,
    output logic [core_pkg::ALEN-1:0] instruction_addr,
    output logic                      stall_next
);
    import core_pkg::*;

    logic [ALEN-1:0] fetch_pc;
    logic            stale;      // Outstanding response belongs to a flushed path.
    logic            out_valid;
    logic            take_resp;
    logic            issue;

    assign take_resp  = imem_valid && !stale && !flush;
    // New request only once the output slot is sure to be free on return.
    assign issue      = !imem_req && !flush && (!out_valid || !next_stalled);
    assign stall_next = !out_valid;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fetch_pc  <= RESET_PC;
            imem_req  <= 1'b0;
            imem_addr <= RESET_PC;
            stale     <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            if (flush) begin
                fetch_pc <= flush_target;
            end else if (take_resp) begin
                fetch_pc <= imem_addr + ALEN'(4);
            end
            if (imem_valid) begin
                imem_req <= 1'b0;
            end else if (issue) begin
                imem_req  <= 1'b1;
                imem_addr <= fetch_pc;  // Held until the response.
            end
            if (imem_valid) begin
                stale <= 1'b0;
            end else if (flush && imem_req) begin
                stale <= 1'b1;
            end
            if (flush) begin
                out_valid <= 1'b0;
            end else if (take_resp) begin
                out_valid <= 1'b1;
            end else if (!next_stalled) begin
                out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take_resp) begin
            instruction      <= imem_rdata;
            instruction_addr <= imem_addr;
        end
    end

endmodule

// ==== source/decode.sv ====
`timescale 1ns/1ps

module decode (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      flush,
    input  core_pkg::instr_t          instruction,
    input  logic [core_pkg::ALEN-1:0] instruction_addr,
    input  logic                      prev_stalled,
    input  logic                      next_stalled,
    input  logic [core_pkg::XLEN-1:0] reg_read1_data,
    input  logic [core_pkg::XLEN-1:0] reg_read2_data,
    input  logic [4:0]                bypass_exec_reg,
    input  logic [core_pkg::XLEN-1:0] bypass_exec_data,
    input  logic                      bypass_exec_valid,
    input  logic [4:0]                bypass_writeback_reg,
    input  logic [core_pkg::XLEN-1:0] bypass_writeback_data,
    input  logic                      bypass_writeback_valid,
    output logic                      stall_prev,
    output logic                      stall_next,
    output logic [4:0]                reg_read1_sel,
    output logic [4:0]                reg_read2_sel,
    output logic [3:0]                alu_op,
    output logic [1:0]                opa_sel,
    output logic                      use_imm,
    output logic [core_pkg::XLEN-1:0] operand_a,
    output logic [core_pkg::XLEN-1:0] operand_b,
    output logic [core_pkg::XLEN-1:0] imm,
    output logic [core_pkg::ALEN-1:0] instr_addr,
    output logic [4:0]                rd,
    output logic                      is_reg_write,
    output logic                      is_branch,
    output logic                      is_jal,
    output logic                      is_jalr,
    output logic [2:0]                funct3
);
    import core_pkg::*;
    import pipe_pkg::*;

    logic            out_valid;
    logic            accept;
    logic            hazard;
    logic [XLEN-1:0] i_imm;
    logic [XLEN-1:0] u_imm;
    logic [XLEN-1:0] b_imm;
    logic [XLEN-1:0] j_imm;
    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;
    logic [3:0]      d_alu_op;
    logic [1:0]      d_opa_sel;
    logic            d_use_imm;
    logic [XLEN-1:0] d_imm;
    logic            d_reg_write;
    logic            d_branch;
    logic            d_jal;
    logic            d_jalr;

    function automatic logic [3:0] alu_decode(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    // Exec result beats writeback, both beat the register file.
    function automatic logic [XLEN-1:0] forward(input logic [4:0] sel,
                                                 input logic [XLEN-1:0] rf_data);
        if (sel == 5'd0) begin
            return rf_data;
        end
        if (bypass_exec_valid && bypass_exec_reg == sel) begin
            return bypass_exec_data;
        end
        if (bypass_writeback_valid && bypass_writeback_reg == sel) begin
            return bypass_writeback_data;
        end
        return rf_data;
    endfunction

    assign reg_read1_sel = instruction.r.rs1;
    assign reg_read2_sel = instruction.r.rs2;

    // Result of the micro-op held here is not visible to any bypass yet.
    assign hazard = out_valid && is_reg_write && rd != 5'd0 &&
                    (rd == instruction.r.rs1 || rd == instruction.r.rs2);
    assign stall_prev = (out_valid && next_stalled) || hazard;
    assign stall_next = !out_valid;
    assign accept     = !prev_stalled && !stall_prev;

    always_comb begin
        i_imm = {{20{instruction.i.imm_hi[11]}}, instruction.i.imm_hi};
        u_imm = {instruction.i.imm_hi, instruction.i.rs1, instruction.i.funct3, 12'b0};
        b_imm = {{20{instruction.r.funct7[6]}}, instruction.r.rd[0],
                 instruction.r.funct7[5:0], instruction.r.rd[4:1], 1'b0};
        j_imm = {{12{instruction.i.imm_hi[11]}}, instruction.i.rs1, instruction.i.funct3,
                 instruction.i.imm_hi[0], instruction.i.imm_hi[10:1], 1'b0};

        d_alu_op    = ALU_ADD;
        d_opa_sel   = OPA_REG;
        d_use_imm   = 1'b1;
        d_imm       = i_imm;
        d_reg_write = 1'b0;  // Unknown opcodes retire silently.
        d_branch    = 1'b0;
        d_jal       = 1'b0;
        d_jalr      = 1'b0;
        case (instruction.r.opcode)
            OPC_OP: begin
                d_alu_op    = alu_decode(instruction.r.funct3, instruction.r.funct7[5]);
                d_use_imm   = 1'b0;
                d_reg_write = 1'b1;
            end
            OPC_OP_IMM: begin
                // Only shifts use bit 30 as a selector.
                d_alu_op    = alu_decode(instruction.r.funct3,
                                         instruction.r.funct3 == 3'b101 &&
                                         instruction.r.funct7[5]);
                d_reg_write = 1'b1;
            end
            OPC_LUI: begin
                d_opa_sel   = OPA_ZERO;
                d_imm       = u_imm;
                d_reg_write = 1'b1;
            end
            OPC_AUIPC: begin
                d_opa_sel   = OPA_PC;
                d_imm       = u_imm;
                d_reg_write = 1'b1;
            end
            OPC_JAL: begin
                d_opa_sel   = OPA_PC;
                d_imm       = j_imm;
                d_reg_write = 1'b1;
                d_jal       = 1'b1;
            end
            OPC_JALR: begin
                d_reg_write = 1'b1;
                d_jalr      = 1'b1;
            end
            OPC_BRANCH: begin
                d_use_imm = 1'b0;  // Comparison uses rs2.
                d_imm     = b_imm;
                d_branch  = 1'b1;
            end
            default: begin
            end
        endcase

        rs1_val = forward(instruction.r.rs1, reg_read1_data);
        rs2_val = forward(instruction.r.rs2, reg_read2_data);
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (flush) begin
            out_valid <= 1'b0;  // Drops the shadow instruction too.
        end else if (accept) begin
            out_valid <= 1'b1;
        end else if (!next_stalled) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            alu_op       <= d_alu_op;
            opa_sel      <= d_opa_sel;
            use_imm      <= d_use_imm;
            operand_a    <= rs1_val;
            operand_b    <= rs2_val;
            imm          <= d_imm;
            instr_addr   <= instruction_addr;
            rd           <= instruction.r.rd;
            is_reg_write <= d_reg_write;
            is_branch    <= d_branch;
            is_jal       <= d_jal;
            is_jalr      <= d_jalr;
            funct3       <= instruction.r.funct3;
        end
    end

endmodule

// ==== source/exec.sv ====
`timescale 1ns/1ps

module exec (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      prev_stalled,
    input  logic [3:0]                alu_op,
    input  logic [1:0]                opa_sel,
    input  logic                      use_imm,
    input  logic [core_pkg::XLEN-1:0] operand_a,
    input  logic [core_pkg::XLEN-1:0] operand_b,
    input  logic [core_pkg::XLEN-1:0] imm,
    input  logic [core_pkg::ALEN-1:0] instr_addr,
    input  logic [4:0]                rd,
    input  logic                      decode_is_reg_write,
    input  logic                      is_branch,
    input  logic                      is_jal,
    input  logic                      is_jalr,
    input  logic [2:0]                funct3,
    output logic                      stall_prev,
    output logic                      stall_next,
    output logic [core_pkg::XLEN-1:0] result,
    output logic [4:0]                reg_write_sel,
    output logic                      is_reg_write,
    output logic                      pipeline_flush,
    output logic [core_pkg::ALEN-1:0] flush_target,
    output logic [core_pkg::ALEN-1:0] next_pc
);
    import core_pkg::*;
    import pipe_pkg::*;

    logic            out_valid;
    logic            accept;
    logic            taken;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_out;
    logic [ALEN-1:0] link_addr;

    assign stall_prev = 1'b0;  // Writeback always drains.
    assign stall_next = !out_valid;
    assign accept     = !prev_stalled && !stall_prev;
    assign link_addr  = instr_addr + ALEN'(4);

    always_comb begin
        case (opa_sel)
            OPA_PC:   op_a = instr_addr;
            OPA_ZERO: op_a = '0;
            default:  op_a = operand_a;
        endcase
        op_b = use_imm ? imm : operand_b;

        case (alu_op)
            ALU_SUB:  alu_out = op_a - op_b;
            ALU_SLL:  alu_out = op_a << op_b[4:0];
            ALU_SLT:  alu_out = XLEN'($signed(op_a) < $signed(op_b));
            ALU_SLTU: alu_out = XLEN'(op_a < op_b);
            ALU_XOR:  alu_out = op_a ^ op_b;
            ALU_SRL:  alu_out = op_a >> op_b[4:0];
            ALU_SRA:  alu_out = $signed(op_a) >>> op_b[4:0];
            ALU_OR:   alu_out = op_a | op_b;
            ALU_AND:  alu_out = op_a & op_b;
            default:  alu_out = op_a + op_b;
        endcase

        case (funct3)
            3'b000:  taken = operand_a == operand_b;
            3'b001:  taken = operand_a != operand_b;
            3'b100:  taken = $signed(operand_a) < $signed(operand_b);
            3'b101:  taken = $signed(operand_a) >= $signed(operand_b);
            3'b110:  taken = operand_a < operand_b;
            3'b111:  taken = operand_a >= operand_b;
            default: taken = 1'b0;
        endcase
    end

    assign flush_target   = is_jalr ? ((operand_a + imm) & ~ALEN'(1)) : instr_addr + imm;
    assign pipeline_flush = accept && (is_jal || is_jalr || (is_branch && taken));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid    <= 1'b0;
            is_reg_write <= 1'b0;
        end else begin
            out_valid    <= accept;
            is_reg_write <= accept && decode_is_reg_write;  // Also the bypass valid.
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            result        <= (is_jal || is_jalr) ? link_addr : alu_out;
            reg_write_sel <= rd;
            next_pc       <= pipeline_flush ? flush_target : link_addr;
        end
    end

endmodule

// ==== source/writeback.sv ====
`timescale 1ns/1ps

module writeback (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      prev_stalled,
    input  logic [core_pkg::XLEN-1:0] result,
    input  logic [4:0]                reg_write_sel,
    input  logic                      is_reg_write,
    input  logic [core_pkg::ALEN-1:0] next_pc,
    output logic                      reg_write_enable,
    output logic [4:0]                reg_write_sel_out,
    output logic [core_pkg::XLEN-1:0] reg_write_data,
    output logic                      instr_retired,
    output logic [core_pkg::ALEN-1:0] writeback_next_pc
);
    import core_pkg::*;

    logic [XLEN-1:0] wb_data;
    logic [4:0]      wb_sel;
    logic [ALEN-1:0] wb_next_pc;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            instr_retired    <= 1'b0;
            reg_write_enable <= 1'b0;
        end else begin
            instr_retired    <= !prev_stalled;  // One pulse per instruction.
            reg_write_enable <= !prev_stalled && is_reg_write;
        end
    end

    always_ff @(posedge clk) begin
        if (!prev_stalled) begin
            wb_data    <= result;
            wb_sel     <= reg_write_sel;
            wb_next_pc <= next_pc;
        end
    end

    // Same values feed the register file and the decode bypass.
    assign reg_write_data    = wb_data;
    assign reg_write_sel_out = wb_sel;
    assign writeback_next_pc = wb_next_pc;

endmodule

// ==== source/core.sv ====
`timescale 1ns/1ps

module core (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      imem_valid,
    input  logic [core_pkg::ILEN-1:0] imem_rdata,
    input  logic [4:0]                reg_read_sel,
    output logic                      imem_req,
    output logic [core_pkg::ALEN-1:0] imem_addr,
    output logic [core_pkg::XLEN-1:0] reg_pc,
    output logic [core_pkg::XLEN-1:0] reg_read_data,
    output logic                      instr_retired
);
    import core_pkg::*;

    logic [ALEN-1:0] pc;
    logic            ifetch_stall_next;
    instr_t          instruction;
    logic [ALEN-1:0] instruction_addr;

    // Decode to exec micro-op, names match the port names.
    logic            decode_stall_prev;
    logic            decode_stall_next;
    logic [4:0]      decode_reg_read1_sel;
    logic [4:0]      decode_reg_read2_sel;
    logic [XLEN-1:0] decode_reg_read1_data;
    logic [XLEN-1:0] decode_reg_read2_data;
    logic [3:0]      alu_op;
    logic [1:0]      opa_sel;
    logic            use_imm;
    logic [XLEN-1:0] operand_a;
    logic [XLEN-1:0] operand_b;
    logic [XLEN-1:0] imm;
    logic [ALEN-1:0] instr_addr;
    logic [4:0]      rd;
    logic            decode_is_reg_write;
    logic            is_branch;
    logic            is_jal;
    logic            is_jalr;
    logic [2:0]      funct3;

    logic            exec_stall_prev;
    logic            exec_stall_next;
    logic [XLEN-1:0] exec_result;
    logic [4:0]      exec_reg_write_sel;
    logic            exec_is_reg_write;
    logic            exec_pipeline_flush;
    logic [ALEN-1:0] exec_flush_target;
    logic [ALEN-1:0] exec_next_pc;

    logic            writeback_reg_write_enable;
    logic [4:0]      writeback_reg_write_sel;
    logic [XLEN-1:0] writeback_reg_write_data;
    logic [ALEN-1:0] writeback_next_pc;

    assign reg_pc = pc;

    pc_control pc_control_i (
        .clk,
        .arst_n,
        .instr_retired,
        .next_pc (writeback_next_pc),
        .pc
    );

    int_regfile regs_i (
        .clk,
        .arst_n,
        .write1_enable (writeback_reg_write_enable),
        .write1_sel    (writeback_reg_write_sel),
        .write1_data   (writeback_reg_write_data),
        .read1_sel     (decode_reg_read1_sel),
        .read2_sel     (decode_reg_read2_sel),
        .read3_sel     (reg_read_sel),
        .read1_data    (decode_reg_read1_data),
        .read2_data    (decode_reg_read2_data),
        .read3_data    (reg_read_data)
    );

    ifetch ifetch_i (
        .flush        (exec_pipeline_flush),
        .flush_target (exec_flush_target),
        .next_stalled (decode_stall_prev),
        .stall_next   (ifetch_stall_next),
        .*
    );

    decode decode_i (
        .flush                  (exec_pipeline_flush),
        .prev_stalled           (ifetch_stall_next),
        .next_stalled           (exec_stall_prev),
        .reg_read1_data         (decode_reg_read1_data),
        .reg_read2_data         (decode_reg_read2_data),
        .bypass_exec_reg        (exec_reg_write_sel),
        .bypass_exec_data       (exec_result),
        .bypass_exec_valid      (exec_is_reg_write),
        .bypass_writeback_reg   (writeback_reg_write_sel),
        .bypass_writeback_data  (writeback_reg_write_data),
        .bypass_writeback_valid (writeback_reg_write_enable),
        .stall_prev             (decode_stall_prev),
        .stall_next             (decode_stall_next),
        .reg_read1_sel          (decode_reg_read1_sel),
        .reg_read2_sel          (decode_reg_read2_sel),
        .is_reg_write           (decode_is_reg_write),
        .*
    );

    exec exec_i (
        .prev_stalled   (decode_stall_next),
        .stall_prev     (exec_stall_prev),
        .stall_next     (exec_stall_next),
        .result         (exec_result),
        .reg_write_sel  (exec_reg_write_sel),
        .is_reg_write   (exec_is_reg_write),
        .pipeline_flush (exec_pipeline_flush),
        .flush_target   (exec_flush_target),
        .next_pc        (exec_next_pc),
        .*
    );

    writeback writeback_i (
        .clk,
        .arst_n,
        .prev_stalled      (exec_stall_next),
        .result            (exec_result),
        .reg_write_sel     (exec_reg_write_sel),
        .is_reg_write      (exec_is_reg_write),
        .next_pc           (exec_next_pc),
        .reg_write_enable  (writeback_reg_write_enable),
        .reg_write_sel_out (writeback_reg_write_sel),
        .reg_write_data    (writeback_reg_write_data),
        .instr_retired,
        .writeback_next_pc
    );

endmodule

// ==== tb/imem_model.sv ====
`timescale 1ns/1ps

module imem_model (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      req,
    input  logic [core_pkg::ALEN-1:0] addr,
    output logic                      valid,
    output core_pkg::instr_t          rdata
);
    import core_pkg::*;

    localparam int DEPTH = 64;

    instr_t          mem [DEPTH];
    logic            busy;
    logic [ALEN-1:0] addr_q;
    int              delay;
    integer          seed;

    initial begin
        seed   = 32492;
        valid  = 1'b0;
        rdata  = '0;
        busy   = 1'b0;
        addr_q = '0;
        delay  = 0;
        // Unused words hold their own index under the custom-0 opcode.
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = {i[24:0], 7'b0001011};
        end
    end

    task automatic write_word(input int index, input logic [31:0] word);
        mem[index] = word;
    endtask

    // Responses change 1 ns after the rising edge, like the other stimulus.
    always begin
        @(posedge clk);
        #1;
        if (!arst_n) begin
            valid = 1'b0;
            busy  = 1'b0;
        end else if (valid) begin
            valid = 1'b0;  // One-cycle pulse.
        end else begin
            if (!busy && req) begin
                busy   = 1'b1;
                addr_q = addr;
                delay  = {$random(seed)} % 4;  // Latency 1 to 4 cycles.
            end
            if (busy) begin
                if (delay == 0) begin
                    valid = 1'b1;
                    rdata = mem[addr_q[7:2]];
                    busy  = 1'b0;
                end else begin
                    delay = delay - 1;
                end
            end
        end
    end

endmodule

// ==== tb/core_tb.sv ====
`timescale 1ns/1ps

module core_tb;
    localparam int          RESET_CYCLES = 16;
    localparam int          RUN_TIMEOUT  = 2000;
    localparam logic [31:0] LOOP_ADDR    = 32'h70;

    // RV32I base opcodes.
    localparam logic [6:0] OPCODE_OP     = 7'b0110011;
    localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPCODE_LUI    = 7'b0110111;
    localparam logic [6:0] OPCODE_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPCODE_JAL    = 7'b1101111;
    localparam logic [6:0] OPCODE_JALR   = 7'b1100111;
    localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;

    logic        clk;
    logic        arst_n;
    logic        imem_valid;
    logic [31:0] imem_rdata;
    logic [4:0]  reg_read_sel;
    logic        imem_req;
    logic [31:0] imem_addr;
    logic [31:0] reg_pc;
    logic [31:0] reg_read_data;
    logic        instr_retired;
    logic        seen_response;
    logic [31:0] expected [32];
    int          errors;
    int          proto_errors;
    int          timeouts;
    int          checks;
    int          cycles;

    core dut_i (
        .clk,
        .arst_n,
        .imem_valid,
        .imem_rdata,
        .reg_read_sel,
        .imem_req,
        .imem_addr,
        .reg_pc,
        .reg_read_data,
        .instr_retired
    );

    imem_model imem_i (
        .clk,
        .arst_n,
        .req   (imem_req),
        .addr  (imem_addr),
        .valid (imem_valid),
        .rdata (imem_rdata)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            seen_response <= 1'b0;
        end else if (imem_valid) begin
            seen_response <= 1'b1;
        end
    end

    // Address must hold while the request waits for its response.
    assert property (@(posedge clk) disable iff (!arst_n)
                     (imem_req && !imem_valid) |=> $stable(imem_addr))
    else begin
        proto_errors++;
        $display("Fetch address changed at %0t ns while a request was outstanding", $time);
    end

    assert property (@(posedge clk) disable iff (!arst_n) !seen_response |-> !instr_retired)
    else begin
        proto_errors++;
        $display("An instruction retired at %0t ns before any fetch response", $time);
    end

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPCODE_OP};
    endfunction

    function automatic logic [31:0] i_type(input logic [6:0] opcode, input logic [4:0] rd,
                                           input logic [2:0] f3, input logic [4:0] rs1,
                                           input logic [11:0] imm);
        return {imm, rs1, f3, rd, opcode};
    endfunction

    function automatic logic [31:0] u_type(input logic [6:0] opcode, input logic [4:0] rd,
                                           input logic [19:0] imm);
        return {imm, rd, opcode};
    endfunction

    function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPCODE_BRANCH};
    endfunction

    function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPCODE_JAL};
    endfunction

    task automatic place_word(input int addr, input logic [31:0] word);
        imem_i.write_word(addr / 4, word);
    endtask

    task automatic load_program();
        place_word('h00, i_type(OPCODE_OP_IMM, 5'd1, 3'b000, 5'd0, 12'd5));
        place_word('h04, i_type(OPCODE_OP_IMM, 5'd2, 3'b000, 5'd0, 12'hffd));  // -3.
        place_word('h08, u_type(OPCODE_LUI, 5'd3, 20'h12345));
        place_word('h0c, r_type(7'b0000000, 5'd2, 5'd1, 3'b000, 5'd4));  // add.
        place_word('h10, r_type(7'b0100000, 5'd3, 5'd4, 3'b000, 5'd5));  // sub.
        place_word('h14, r_type(7'b0000000, 5'd4, 5'd5, 3'b100, 5'd6));  // xor.
        place_word('h18, r_type(7'b0000000, 5'd1, 5'd6, 3'b001, 5'd7));  // sll.
        place_word('h1c, r_type(7'b0100000, 5'd4, 5'd7, 3'b101, 5'd8));  // sra.
        place_word('h20, r_type(7'b0000000, 5'd1, 5'd8, 3'b011, 5'd9));  // sltu.
        place_word('h24, b_type(3'b000, 5'd4, 5'd4, 13'd12));  // beq, taken.
        place_word('h28, i_type(OPCODE_OP_IMM, 5'd10, 3'b000, 5'd0, 12'd111));
        place_word('h2c, i_type(OPCODE_OP_IMM, 5'd11, 3'b000, 5'd0, 12'd222));
        place_word('h30, b_type(3'b001, 5'd1, 5'd1, 13'd8));   // bne, not taken.
        place_word('h34, i_type(OPCODE_OP_IMM, 5'd12, 3'b000, 5'd0, 12'd77));
        place_word('h38, j_type(5'd13, 21'd12));
        place_word('h3c, i_type(OPCODE_OP_IMM, 5'd10, 3'b000, 5'd0, 12'd1));
        place_word('h40, i_type(OPCODE_OP_IMM, 5'd11, 3'b000, 5'd0, 12'd2));
        place_word('h44, i_type(OPCODE_OP_IMM, 5'd14, 3'b000, 5'd0, 12'h060));
        place_word('h48, i_type(OPCODE_JALR, 5'd15, 3'b000, 5'd14, 12'd4));
        place_word('h4c, i_type(OPCODE_OP_IMM, 5'd10, 3'b000, 5'd0, 12'd3));
        place_word('h64, u_type(OPCODE_AUIPC, 5'd16, 20'h00001));
        place_word('h68, i_type(OPCODE_OP_IMM, 5'd0, 3'b000, 5'd1, 12'd99));  // To x0.
        place_word('h6c, r_type(7'b0000000, 5'd1, 5'd0, 3'b000, 5'd17));
        place_word('h70, j_type(5'd0, 21'd0));  // Final self-loop.
    endtask

    task automatic set_expected();
        for (int r = 0; r < 32; r++) begin
            expected[r] = 32'd0;  // Shadow targets x10, x11 stay here.
        end
        expected[1]  = 32'd5;
        expected[2]  = 32'd0 - 32'd3;
        expected[3]  = 32'h12345 << 12;
        expected[4]  = expected[1] + expected[2];
        expected[5]  = expected[4] - expected[3];
        expected[6]  = expected[5] ^ expected[4];
        expected[7]  = expected[6] << expected[1][4:0];
        expected[8]  = $signed(expected[7]) >>> expected[4][4:0];
        // Negative x8 against 5 tells unsigned from signed compare.
        expected[9]  = (expected[8] < expected[1]) ? 32'd1 : 32'd0;
        expected[12] = 32'd77;
        expected[13] = 32'h38 + 32'd4;  // Link of the JAL.
        expected[14] = 32'h60;
        expected[15] = 32'h48 + 32'd4;
        expected[16] = 32'h64 + 32'h1000;
        expected[17] = expected[1];
    endtask

    task automatic check_reg(input logic [4:0] index);
        logic [31:0] got;
        @(posedge clk);
        #1;
        reg_read_sel = index;
        @(negedge clk);
        got = reg_read_data;
        checks++;
        assert (got === expected[index])
        else begin
            errors++;
            $display("Error at %0t ns: x%0d reads %h, expected %h",
                     $time, index, got, expected[index]);
        end
    endtask

    initial begin
        arst_n       = 1'b0;
        reg_read_sel = 5'd0;
        errors       = 0;
        proto_errors = 0;
        timeouts     = 0;
        checks       = 0;
        cycles       = 0;
        #1;
        load_program();
        set_expected();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        arst_n = 1'b1;
        // reg_pc reaches the loop once everything before it has retired.
        while (reg_pc !== LOOP_ADDR && cycles < RUN_TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (reg_pc !== LOOP_ADDR) begin
            timeouts++;
            $display("Timed out after %0d cycles waiting for the final loop, PC is %h",
                     cycles, reg_pc);
        end else begin
            for (int r = 0; r < 32; r++) begin
                check_reg(r[4:0]);
            end
        end
        $display("Checks %0d, value errors %0d, protocol errors %0d, timeouts %0d",
                 checks, errors, proto_errors, timeouts);
        if (errors == 0 && proto_errors == 0 && timeouts == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== src.f ====
source/core_pkg.sv
source/pipe_pkg.sv
source/pc_control.sv
source/int_regfile.sv
source/ifetch.sv
source/decode.sv
source/exec.sv
source/writeback.sv
source/core.sv
tb/imem_model.sv
tb/core_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 --top-module core_tb -f src.f -o core_tb; then
    echo "Compilation failed"
    exit 1
fi

output=$(./obj_dir/core_tb)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "No errors" <<< "$output"; then
    exit 0
else
    exit 1
fi
